/* dds_gen.sv */
// Direct digital synthesizer with a 256-entry sine table
// Emits TX_PAR_SAMPLES samples per channel per cycle
`timescale 1ns/1ps
`include "tx_macros.svh"

module dds_gen (
  input  logic                                   dac_clk,
  input  logic                                   reset,
  tx_config_if.user                              cfg,
  output tx_pkg::sample_vec_t [`TX_CHANNELS-1:0] data,
  output logic [`TX_CHANNELS-1:0]                valid
);

  localparam int  LUT_SIZE = 2 ** `TX_LUT_BITS;
  localparam int  AMPL     = 2 ** (`TX_SAMPLE_WIDTH - 1) - 1;
  localparam real PI       = 3.141592653589793;

  typedef tx_pkg::sample_t lut_t [LUT_SIZE];

  // Sine table built at elaboration, rounded to nearest
  function automatic lut_t make_sine_lut();
    lut_t lut;
    for (int i = 0; i < LUT_SIZE; i++) begin
      lut[i] = tx_pkg::sample_t'(int'(real'(AMPL) * $sin(2.0 * PI * i / LUT_SIZE)));
    end
    return lut;
  endfunction

  localparam lut_t SINE_LUT = make_sine_lut();

  //////////////////////////////
  // Phase accumulator stage
  //////////////////////////////

  tx_pkg::phase_t [`TX_CHANNELS-1:0]     acc;
  tx_pkg::phase_t [`TX_CHANNELS-1:0]     base;
  tx_pkg::phase_t [`TX_PAR_SAMPLES-1:0]  phase_s1 [`TX_CHANNELS];
  logic [`TX_CHANNELS-1:0]               valid_s1;

  // Restart begins the sequence at phase zero
  always_comb begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      base[c] = cfg.restart ? '0 : acc[c];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      acc      <= '0;
      valid_s1 <= '0;
      valid    <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        valid_s1[c] <= cfg.run;
        valid[c]    <= valid_s1[c];
        // Phase holds while stopped
        if (cfg.run) begin
          acc[c] <= base[c] + tx_pkg::phase_t'(`TX_ACC_STEP) * cfg.dds_inc[c];
        end else if (cfg.restart) begin
          acc[c] <= '0;
        end
      end
    end
  end

  //////////////////////////////
  // Table lookup stage
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      for (int j = 0; j < `TX_PAR_SAMPLES; j++) begin
        // Sample j sits j increments past the cycle base
        phase_s1[c][j] <= base[c] + tx_pkg::phase_t'(j) * cfg.dds_inc[c];
        data[c][j]     <= SINE_LUT[phase_s1[c][j][`TX_PHASE_BITS-1 -: `TX_LUT_BITS]];
      end
    end
  end

endmodule

/* flist.f */
+incdir+.
tx_pkg.sv
tx_config_if.sv
tx_config_regs.sv
dds_gen.sv
tri_gen.sv
realtime_channel_mux.sv
realtime_affine.sv
transmit_top.sv
tb_transmit_top.sv

/* realtime_affine.sv */
// Two-stage prescaler per channel
// Product, then floor shift, offset and saturation
`timescale 1ns/1ps
`include "tx_macros.svh"

module realtime_affine (
  input  logic                                   dac_clk,
  input  logic                                   reset,
  input  tx_pkg::sample_vec_t [`TX_CHANNELS-1:0] in_data,
  input  logic [`TX_CHANNELS-1:0]                in_valid,
  tx_config_if.user                              cfg,
  output tx_pkg::sample_vec_t [`TX_CHANNELS-1:0] out_data,
  output logic [`TX_CHANNELS-1:0]                out_valid
);

  localparam int PROD_W = 2 * `TX_SAMPLE_WIDTH;
  localparam int S_MAX  = 2 ** (`TX_SAMPLE_WIDTH - 1) - 1;
  localparam int S_MIN  = -(2 ** (`TX_SAMPLE_WIDTH - 1));

  logic signed [PROD_W-1:0]  prod_s1 [`TX_CHANNELS][`TX_PAR_SAMPLES];
  logic [`TX_CHANNELS-1:0]   valid_s1;

  // Clamp to the sample range
  function automatic tx_pkg::sample_t saturate(input logic signed [PROD_W:0] v);
    if (v > S_MAX) begin
      return tx_pkg::sample_t'(S_MAX);
    end
    if (v < S_MIN) begin
      return tx_pkg::sample_t'(S_MIN);
    end
    return v[`TX_SAMPLE_WIDTH-1:0];
  endfunction

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      valid_s1  <= '0;
      out_valid <= '0;
    end else begin
      valid_s1  <= in_valid;
      out_valid <= valid_s1;
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      for (int j = 0; j < `TX_PAR_SAMPLES; j++) begin
        // Stage 1, full-precision product
        prod_s1[c][j]  <= $signed(in_data[c][j]) * $signed(cfg.scale[c]);
        // Stage 2, arithmetic shift rounds toward minus infinity
        out_data[c][j] <= saturate((prod_s1[c][j] >>> `TX_SCALE_FRAC) + cfg.offset[c]);
      end
    end
  end

  // Valid pipeline depth matches the data path
  a_valid_latency: assert property (@(posedge dac_clk) disable iff (reset)
    out_valid == $past(in_valid, 2));

endmodule

/* realtime_channel_mux.sv */
// Registered source selector
// Any of the four generator channels onto each output channel
`timescale 1ns/1ps
`include "tx_macros.svh"

module realtime_channel_mux (
  input  logic                                       dac_clk,
  input  logic                                       reset,
  input  tx_pkg::sample_vec_t [`TX_SRC_CHANNELS-1:0] src_data,
  input  logic [`TX_SRC_CHANNELS-1:0]                src_valid,
  tx_config_if.user                                  cfg,
  output tx_pkg::sample_vec_t [`TX_CHANNELS-1:0]     data,
  output logic [`TX_CHANNELS-1:0]                    valid
);

  // Valid follows the selected source and idles in reset
  always_ff @(posedge dac_clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        valid[c] <= src_valid[cfg.mux_sel[c]];
      end
    end
  end

  // Sample payload
  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      data[c] <= src_data[cfg.mux_sel[c]];
    end
  end

  // Routing must be a known value once the register block is out of reset
  a_mux_sel_known: assert property (@(posedge dac_clk) disable iff (reset)
    !$isunknown(cfg.mux_sel));

endmodule

/* tb_transmit_top.sv */
// Seeded random testbench for the transmit chain
// Reference model of sources, routing and prescaler, sample monitor and watchdog
`timescale 1ns/1ps
`include "tx_macros.svh"

module tb_transmit_top;

  localparam int CLK_PERIOD = 8;
  localparam int N_CH       = `TX_CHANNELS;
  localparam int N_PAR      = `TX_PAR_SAMPLES;
  localparam int SW         = `TX_SAMPLE_WIDTH;

  // Cycle budget of the register test plus sixteen bursts of config, run and drain
  localparam int REG_CYCLES = 400;
  localparam int RUN_CYCLES = 120;
  localparam int N_RUNS     = 16;
  localparam int LIMIT_NS   = (REG_CYCLES + N_RUNS * RUN_CYCLES) * CLK_PERIOD + 4000;

  logic                      dac_clk;
  logic                      reset;
  logic [7:0]                paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  logic [N_CH*N_PAR*SW-1:0]  dac_data;
  logic [N_CH-1:0]           dac_valid;

  // Reference model state
  logic                      model_run;
  logic [1:0]                model_mux [N_CH];
  logic [31:0]               model_dds_inc [N_CH];
  logic [31:0]               model_tri_inc [N_CH];
  logic signed [15:0]        model_scale [N_CH];
  logic signed [15:0]        model_offset [N_CH];
  int                        sine_ref [256];

  // Progress and bookkeeping
  int    errors        = 0;
  int    checks        = 0;
  int    cycle_cnt     = 0;
  int    last_wr_cycle = 0;
  int    run_cycle     = 0;
  int    exp_idx [N_CH];
  bit    seen_first [N_CH];
  string test_name;

  transmit_top i_transmit_top (
    .dac_clk,
    .reset,
    .paddr,
    .psel,
    .penable,
    .pwrite,
    .pwdata,
    .prdata,
    .pready,
    .pslverr,
    .dac_data,
    .dac_valid
  );

  initial dac_clk = 1'b0;
  always #(CLK_PERIOD / 2) dac_clk = ~dac_clk;

  always @(posedge dac_clk) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////
  // Checking and model
  //////////////////////////////

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %08h actual %08h", test_name, what, expected, actual);
    end
  endtask

  // round(32767 sin(2 pi i / 256)) with halves away from zero
  task automatic fill_sine_table();
    real x;
    for (int i = 0; i < 256; i++) begin
      x = 32767.0 * $sin(2.0 * 3.141592653589793 * i / 256.0);
      sine_ref[i] = (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
    end
  endtask

  function automatic logic [7:0] channel_addr(input logic [7:0] base, input int c);
    return base + 8'(4 * c);
  endfunction

  function automatic bit is_mapped(input logic [7:0] addr);
    bit hit;
    hit = (addr == `TX_REG_CTRL) || (addr == `TX_REG_MUX);
    for (int c = 0; c < N_CH; c++) begin
      hit |= (addr == channel_addr(`TX_REG_DDS_INC, c));
      hit |= (addr == channel_addr(`TX_REG_TRI_INC, c));
      hit |= (addr == channel_addr(`TX_REG_SCALE_OFFSET, c));
    end
    return hit;
  endfunction

  // Register word the model holds at this address
  function automatic logic [31:0] expected_reg(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    if (addr == `TX_REG_CTRL) v[0] = model_run;
    for (int c = 0; c < N_CH; c++) begin
      if (addr == `TX_REG_MUX) v[2*c +: 2] = model_mux[c];
      if (addr == channel_addr(`TX_REG_DDS_INC, c)) v = model_dds_inc[c];
      if (addr == channel_addr(`TX_REG_TRI_INC, c)) v = model_tri_inc[c];
      if (addr == channel_addr(`TX_REG_SCALE_OFFSET, c)) v = {model_scale[c], model_offset[c]};
    end
    return v;
  endfunction

  // Sources 0..N_CH-1 are sine, the rest triangle
  function automatic int source_sample(input int src, input int n);
    logic [31:0] ph;
    int          u;
    if (src < N_CH) begin
      ph = model_dds_inc[src] * 32'(n);
      return sine_ref[ph[31:24]];
    end
    ph = model_tri_inc[src - N_CH] * 32'(n);
    u  = ph[30:16];
    return ph[31] ? 32767 - 2 * u : 2 * u - 32768;
  endfunction

  // Floor shift of the Q2.14 product, offset, then clamp
  function automatic int expected_output(input int c, input int n);
    int s;
    int p;
    int v;
    s = source_sample(model_mux[c], n);
    p = s * model_scale[c];
    v = (p >>> `TX_SCALE_FRAC) + model_offset[c];
    if (v > 32767) v = 32767;
    if (v < -32768) v = -32768;
    return v;
  endfunction

  //////////////////////////////
  // APB driver
  //////////////////////////////

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(negedge dac_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge dac_clk);
    penable       = 1'b1;
    last_wr_cycle = cycle_cnt + 1;
    // Response registered on the setup edge
    rdata = prdata;
    err   = pslverr;
    @(negedge dac_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    if (addr == `TX_REG_CTRL) begin
      model_run = data[0];
      // New sequence starts from index 0
      if (data[0]) begin
        for (int c = 0; c < N_CH; c++) begin
          exp_idx[c]    = 0;
          seen_first[c] = 1'b0;
        end
      end
    end
    for (int c = 0; c < N_CH; c++) begin
      if (addr == `TX_REG_MUX) model_mux[c] = data[2*c +: 2];
      if (addr == channel_addr(`TX_REG_DDS_INC, c)) model_dds_inc[c] = data;
      if (addr == channel_addr(`TX_REG_TRI_INC, c)) model_tri_inc[c] = data;
      if (addr == channel_addr(`TX_REG_SCALE_OFFSET, c)) begin
        model_scale[c]  = data[31:16];
        model_offset[c] = data[15:0];
      end
    end
    apb_transfer(1'b1, addr, data, rd, err);
    compare($sformatf("write 0x%02h pslverr", addr), !is_mapped(addr), err);
    if (addr == `TX_REG_CTRL && data[0]) run_cycle = last_wr_cycle;
  endtask

  task automatic reg_read(input logic [7:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b0, addr, '0, rd, err);
    compare($sformatf("read 0x%02h pslverr", addr), !is_mapped(addr), err);
    if (is_mapped(addr)) compare($sformatf("read 0x%02h data", addr), expected_reg(addr), rd);
  endtask

  task automatic randomize_increments();
    for (int c = 0; c < N_CH; c++) begin
      reg_write(channel_addr(`TX_REG_DDS_INC, c), $urandom());
      reg_write(channel_addr(`TX_REG_TRI_INC, c), $urandom());
    end
  endtask

  // Run, stop, wait for the stream to drain, then check the sample count
  task automatic run_burst(input int cycles);
    int start;
    int guard;
    reg_write(`TX_REG_CTRL, 32'h1);
    start = last_wr_cycle;
    repeat (cycles) @(negedge dac_clk);
    reg_write(`TX_REG_CTRL, 32'h0);
    guard = 0;
    while (dac_valid != '0 && guard < 20) begin
      @(negedge dac_clk);
      guard++;
    end
    if (dac_valid != '0) begin
      errors++;
      $display("%s: dac_valid still high 20 cycles after run was cleared", test_name);
    end else begin
      compare("stop to idle delay", 5, cycle_cnt - last_wr_cycle);
    end
    for (int c = 0; c < N_CH; c++) begin
      compare($sformatf("ch%0d sample count", c), N_PAR * (last_wr_cycle - start), exp_idx[c]);
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge dac_clk) begin : monitor
    logic signed [SW-1:0] got;
    if (!reset) begin
      for (int c = 0; c < N_CH; c++) begin
        if (dac_valid[c]) begin
          if (!seen_first[c]) begin
            compare($sformatf("ch%0d first valid delay", c), 5, cycle_cnt - run_cycle);
            seen_first[c] = 1'b1;
          end
          for (int j = 0; j < N_PAR; j++) begin
            got = dac_data[(c * N_PAR + j) * SW +: SW];
            compare($sformatf("ch%0d sample %0d", c, exp_idx[c] + j),
                    expected_output(c, exp_idx[c] + j), got);
          end
          exp_idx[c] += N_PAR;
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(LIMIT_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", LIMIT_NS);
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [7:0]  a;
    logic [31:0] d;
    logic [1:0]  s;
    logic [7:0]  reg_addrs [$];
    void'($urandom(32'h19e4c9aa));
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    reset   = 1'b1;
    fill_sine_table();
    // Reset state of the register map
    model_run = 1'b0;
    for (int c = 0; c < N_CH; c++) begin
      model_mux[c]     = 2'(c);
      model_dds_inc[c] = '0;
      model_tri_inc[c] = '0;
      model_scale[c]   = 16'h4000;
      model_offset[c]  = '0;
      exp_idx[c]       = 0;
      seen_first[c]    = 1'b1;
    end
    reg_addrs.push_back(`TX_REG_CTRL);
    reg_addrs.push_back(`TX_REG_MUX);
    for (int c = 0; c < N_CH; c++) begin
      reg_addrs.push_back(channel_addr(`TX_REG_DDS_INC, c));
      reg_addrs.push_back(channel_addr(`TX_REG_TRI_INC, c));
      reg_addrs.push_back(channel_addr(`TX_REG_SCALE_OFFSET, c));
    end
    repeat (3) @(negedge dac_clk);
    reset = 1'b0;

    // Reset values, random write and read back, unmapped addresses
    test_name = "register_access";
    compare("pready", 1, pready);
    // Stream and APB response idle out of reset
    compare("prdata after reset", 0, prdata);
    compare("pslverr after reset", 0, pslverr);
    compare("dac_valid after reset", 0, dac_valid);
    foreach (reg_addrs[i]) reg_read(reg_addrs[i]);
    repeat (20) begin
      a = reg_addrs[$urandom_range(0, reg_addrs.size() - 1)];
      d = $urandom();
      // Keep the chain stopped
      if (a == `TX_REG_CTRL) d[0] = 1'b0;
      reg_write(a, d);
      reg_read(a);
    end
    repeat (10) begin
      do a = 8'($urandom_range(0, 63)) << 2; while (is_mapped(a));
      reg_write(a, $urandom());
      reg_read(a);
    end
    foreach (reg_addrs[i]) reg_read(reg_addrs[i]);

    // Identity routing, unit gain, zero offset
    test_name = "sine";
    reg_write(`TX_REG_MUX, 32'h4);
    for (int c = 0; c < N_CH; c++) reg_write(channel_addr(`TX_REG_SCALE_OFFSET, c), 32'h4000_0000);
    repeat (2) begin
      randomize_increments();
      run_burst($urandom_range(16, 48));
    end

    test_name = "triangle_mux";
    for (int k = 0; k < 6; k++) begin
      d = $urandom_range(0, 15);
      // Both outputs on one triangle, then both on one random source
      if (k == 0) d = 32'ha;
      s = 2'($urandom());
      if (k == 1) d = {28'd0, s, s};
      reg_write(`TX_REG_MUX, d);
      randomize_increments();
      run_burst($urandom_range(16, 48));
    end

    test_name = "scale_offset";
    for (int k = 0; k < 6; k++) begin
      reg_write(`TX_REG_MUX, $urandom_range(0, 15));
      for (int c = 0; c < N_CH; c++) begin
        d = $urandom();
        // Large gain with extreme offsets drives both rails
        if (k == 0) d = 32'h7fff_7fff;
        if (k == 1) d = 32'h8000_8000;
        reg_write(channel_addr(`TX_REG_SCALE_OFFSET, c), d);
      end
      randomize_increments();
      run_burst($urandom_range(16, 48));
    end

    // Second run with the same settings starts again at index 0
    test_name = "stop_restart";
    run_burst(20);
    run_burst(20);

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* transmit_top.sv */
// Transmit chain top level
// APB register block, sine and triangle sources, channel mux and prescaler
`timescale 1ns/1ps
`include "tx_macros.svh"

module transmit_top (
  input  logic                                                      dac_clk,
  input  logic                                                      reset,
  // APB slave
  input  logic [`TX_APB_ADDR_WIDTH-1:0]                             paddr,
  input  logic                                                      psel,
  input  logic                                                      penable,
  input  logic                                                      pwrite,
  input  logic [`TX_APB_DATA_WIDTH-1:0]                             pwdata,
  output logic [`TX_APB_DATA_WIDTH-1:0]                             prdata,
  output logic                                                      pready,
  output logic                                                      pslverr,
  // DAC stream, channel 0 in the low bits
  output logic [`TX_CHANNELS*`TX_PAR_SAMPLES*`TX_SAMPLE_WIDTH-1:0]  dac_data,
  output logic [`TX_CHANNELS-1:0]                                   dac_valid
);

  //////////////////////////////
  // Configuration
  //////////////////////////////

  tx_config_if cfg ();

  tx_config_regs regs_i (
    .dac_clk,
    .reset,
    .paddr,
    .psel,
    .penable,
    .pwrite,
    .pwdata,
    .prdata,
    .pready,
    .pslverr,
    .cfg     (cfg.regs)
  );

  //////////////////////////////
  // Signal chain
  //////////////////////////////

  tx_pkg::sample_vec_t [`TX_CHANNELS-1:0]     dds_data;
  tx_pkg::sample_vec_t [`TX_CHANNELS-1:0]     tri_data;
  tx_pkg::sample_vec_t [`TX_SRC_CHANNELS-1:0] src_data;
  tx_pkg::sample_vec_t [`TX_CHANNELS-1:0]     mux_data;
  tx_pkg::sample_vec_t [`TX_CHANNELS-1:0]     aff_data;
  logic [`TX_CHANNELS-1:0]                    dds_valid;
  logic [`TX_CHANNELS-1:0]                    tri_valid;
  logic [`TX_SRC_CHANNELS-1:0]                src_valid;
  logic [`TX_CHANNELS-1:0]                    mux_valid;

  dds_gen dds_i (
    .dac_clk,
    .reset,
    .cfg   (cfg.user),
    .data  (dds_data),
    .valid (dds_valid)
  );

  tri_gen tri_i (
    .dac_clk,
    .reset,
    .cfg   (cfg.user),
    .data  (tri_data),
    .valid (tri_valid)
  );

  // Sources 0..1 are sine, 2..3 triangle
  assign src_data  = {tri_data, dds_data};
  assign src_valid = {tri_valid, dds_valid};

  realtime_channel_mux channel_mux_i (
    .dac_clk,
    .reset,
    .src_data,
    .src_valid,
    .cfg       (cfg.user),
    .data      (mux_data),
    .valid     (mux_valid)
  );

  realtime_affine prescaler_i (
    .dac_clk,
    .reset,
    .in_data   (mux_data),
    .in_valid  (mux_valid),
    .cfg       (cfg.user),
    .out_data  (aff_data),
    .out_valid (dac_valid)
  );

  // Packed layout already has channel 0, sample 0 lowest
  assign dac_data = aff_data;

endmodule

/* tri_gen.sv */
// Triangle generator on a phase accumulator
// Latency matched to the sine synthesizer
`timescale 1ns/1ps
`include "tx_macros.svh"

module tri_gen (
  input  logic                                   dac_clk,
  input  logic                                   reset,
  tx_config_if.user                              cfg,
  output tx_pkg::sample_vec_t [`TX_CHANNELS-1:0] data,
  output logic [`TX_CHANNELS-1:0]                valid
);

  localparam int U_BITS = `TX_SAMPLE_WIDTH - 1;

  // Rising half gives 2u - 32768, falling half 32767 - 2u
  // which is the bitwise inverse of the rising value
  function automatic tx_pkg::sample_t tri_wave(input tx_pkg::phase_t ph);
    logic [U_BITS-1:0] u;
    tx_pkg::sample_t   rise;
    u    = ph[`TX_PHASE_BITS-2 -: U_BITS];
    rise = {~u[U_BITS-1], u[U_BITS-2:0], 1'b0};
    return ph[`TX_PHASE_BITS-1] ? ~rise : rise;
  endfunction

  tx_pkg::phase_t [`TX_CHANNELS-1:0]     acc;
  tx_pkg::phase_t [`TX_CHANNELS-1:0]     base;
  tx_pkg::phase_t [`TX_PAR_SAMPLES-1:0]  phase_s1 [`TX_CHANNELS];
  logic [`TX_CHANNELS-1:0]               valid_s1;

  always_comb begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      base[c] = cfg.restart ? '0 : acc[c];
    end
  end

  // Accumulator and valid pipeline
  always_ff @(posedge dac_clk) begin
    if (reset) begin
      acc      <= '0;
      valid_s1 <= '0;
      valid    <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        valid_s1[c] <= cfg.run;
        valid[c]    <= valid_s1[c];
        if (cfg.run) begin
          acc[c] <= base[c] + tx_pkg::phase_t'(`TX_ACC_STEP) * cfg.tri_inc[c];
        end else if (cfg.restart) begin
          acc[c] <= '0;
        end
      end
    end
  end

  // Phase register, then waveform output register
  always_ff @(posedge dac_clk) begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      for (int j = 0; j < `TX_PAR_SAMPLES; j++) begin
        phase_s1[c][j] <= base[c] + tx_pkg::phase_t'(j) * cfg.tri_inc[c];
        data[c][j]     <= tri_wave(phase_s1[c][j]);
      end
    end
  end

endmodule

/* tx_config_if.sv */
// Configuration bundle from the APB register block to the datapath
`timescale 1ns/1ps
`include "tx_macros.svh"

interface tx_config_if;

  // Global run state and one-cycle restart strobe
  logic run;
  logic restart;

  // Per-channel generator increments
  tx_pkg::phase_t [`TX_CHANNELS-1:0] dds_inc;
  tx_pkg::phase_t [`TX_CHANNELS-1:0] tri_inc;

  // Source routing per output channel
  tx_pkg::src_sel_t [`TX_CHANNELS-1:0] mux_sel;

  // Prescaler settings per output channel
  tx_pkg::scale_t [`TX_CHANNELS-1:0] scale;
  tx_pkg::offset_t [`TX_CHANNELS-1:0] offset;

  // Register block side
  modport regs (output run, restart, dds_inc, tri_inc, mux_sel, scale, offset);

  // Datapath side
  modport user (input run, restart, dds_inc, tri_inc, mux_sel, scale, offset);

endinterface

/* tx_config_regs.sv */
// APB slave with the transmit chain register map
// Drives run, restart, routing, increments and prescaler settings
`timescale 1ns/1ps
`include "tx_macros.svh"

module tx_config_regs (
  input  logic                            dac_clk,
  input  logic                            reset,
  input  logic [`TX_APB_ADDR_WIDTH-1:0]   paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [`TX_APB_DATA_WIDTH-1:0]   pwdata,
  output logic [`TX_APB_DATA_WIDTH-1:0]   prdata,
  output logic                            pready,
  output logic                            pslverr,
  tx_config_if.regs                       cfg
);

  //////////////////////////////
  // Address decode
  //////////////////////////////

  logic                          wr_en;
  logic                          setup;
  logic                          hit;
  logic [`TX_APB_DATA_WIDTH-1:0] rd_data;

  // Write lands on the access phase edge
  assign wr_en = psel && penable && pwrite;
  assign setup = psel && !penable;

  // No wait states
  assign pready = 1'b1;

  // Per-channel register address
  function automatic logic [`TX_APB_ADDR_WIDTH-1:0] ch_addr(
    input logic [`TX_APB_ADDR_WIDTH-1:0] base,
    input int                            ch
  );
    return base + `TX_APB_ADDR_WIDTH'(`TX_REG_STRIDE * ch);
  endfunction

  always_comb begin
    hit     = 1'b0;
    rd_data = '0;
    if (paddr == `TX_REG_CTRL) begin
      hit        = 1'b1;
      rd_data[0] = cfg.run;
    end
    if (paddr == `TX_REG_MUX) begin
      hit = 1'b1;
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        rd_data[2*c +: 2] = cfg.mux_sel[c];
      end
    end
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      if (paddr == ch_addr(`TX_REG_DDS_INC, c)) begin
        hit     = 1'b1;
        rd_data = cfg.dds_inc[c];
      end
      if (paddr == ch_addr(`TX_REG_TRI_INC, c)) begin
        hit     = 1'b1;
        rd_data = cfg.tri_inc[c];
      end
      // Scale in the upper half
      if (paddr == ch_addr(`TX_REG_SCALE_OFFSET, c)) begin
        hit     = 1'b1;
        rd_data = {cfg.scale[c], cfg.offset[c]};
      end
    end
  end

  //////////////////////////////
  // Register storage
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      cfg.run     <= 1'b0;
      cfg.restart <= 1'b0;
      cfg.dds_inc <= '0;
      cfg.tri_inc <= '0;
      cfg.offset  <= '0;
      prdata      <= '0;
      pslverr     <= 1'b0;
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        // Identity routing, unit gain
        cfg.mux_sel[c] <= tx_pkg::src_sel_t'(c);
        cfg.scale[c]   <= `TX_SCALE_ONE;
      end
    end else begin
      cfg.restart <= 1'b0;
      // Read data and error are sampled in setup, held through access
      prdata      <= setup ? rd_data : '0;
      pslverr     <= setup && !hit;
      if (wr_en) begin
        if (paddr == `TX_REG_CTRL) begin
          cfg.run     <= pwdata[0];
          cfg.restart <= 1'b1;
        end
        for (int c = 0; c < `TX_CHANNELS; c++) begin
          if (paddr == `TX_REG_MUX) begin
            cfg.mux_sel[c] <= tx_pkg::src_sel_t'(pwdata[2*c +: 2]);
          end
          if (paddr == ch_addr(`TX_REG_DDS_INC, c)) begin
            cfg.dds_inc[c] <= pwdata;
          end
          if (paddr == ch_addr(`TX_REG_TRI_INC, c)) begin
            cfg.tri_inc[c] <= pwdata;
          end
          if (paddr == ch_addr(`TX_REG_SCALE_OFFSET, c)) begin
            cfg.scale[c]  <= pwdata[31:16];
            cfg.offset[c] <= pwdata[15:0];
          end
        end
      end
    end
  end

  // APB access phase only follows a selected setup
  a_penable_psel: assert property (@(posedge dac_clk) disable iff (reset)
    penable |-> psel && $past(psel));

endmodule

/* tx_macros.svh */
// Register map, datapath widths and accumulator step
// for the transmit signal chain
`ifndef TX_MACROS_SVH
`define TX_MACROS_SVH

// Datapath shape
`define TX_CHANNELS 2
`define TX_SRC_CHANNELS (2 * `TX_CHANNELS)
`define TX_PAR_SAMPLES 2
`define TX_SAMPLE_WIDTH 16
`define TX_PHASE_BITS 32
`define TX_LUT_BITS 8
`define TX_SCALE_FRAC 14
`define TX_SCALE_ONE 16'h4000

// Phase advance per cycle, in units of the increment
`define TX_ACC_STEP `TX_PAR_SAMPLES

// APB register map
`define TX_APB_ADDR_WIDTH 8
`define TX_APB_DATA_WIDTH 32
`define TX_REG_STRIDE 4
`define TX_REG_CTRL 8'h00
`define TX_REG_MUX 8'h04
`define TX_REG_DDS_INC 8'h10
`define TX_REG_TRI_INC 8'h20
`define TX_REG_SCALE_OFFSET 8'h30

`endif

/* tx_pkg.sv */
// Sample, parallel vector and configuration types
// shared across the transmit chain
`include "tx_macros.svh"

package tx_pkg;

  // One signed DAC sample
  typedef logic signed [`TX_SAMPLE_WIDTH-1:0] sample_t;

  // Parallel samples of one channel in one cycle
  // index 0 is the earliest in time
  typedef sample_t [`TX_PAR_SAMPLES-1:0] sample_vec_t;

  // Accumulator phase, full turn is 2**TX_PHASE_BITS
  typedef logic [`TX_PHASE_BITS-1:0] phase_t;

  // Source index for the channel mux
  typedef enum logic [1:0] {
    SRC_DDS0 = 2'd0,
    SRC_DDS1 = 2'd1,
    SRC_TRI0 = 2'd2,
    SRC_TRI1 = 2'd3
  } src_sel_t;

  // Prescaler gain in Q2.14
  typedef logic signed [15:0] scale_t;

  // Prescaler offset in sample units
  typedef logic signed [15:0] offset_t;

endpackage
